//--- list.f
+incdir+.
core_pkg.sv
stage_if.sv
pipeline_1_fe.sv
pipeline_2_ex.sv
pipeline_3_ma.sv
rf_controller.sv
hardisc_lite.sv
tb_hardisc_lite.sv

//--- Makefile
# Build and run the core testbench with Verilator

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_hardisc_lite -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- tb_hardisc_lite.sv
// Testbench for the three stage core
`timescale 1ns/10ps
`include "core_defs.svh"

module tb_hardisc_lite;

    localparam logic [31:0] boot_pc  = 32'h0000_0080;
    localparam int          prog_len = 113;            // 96 random, 15 closing stores, halt pair
    localparam logic [31:0] nop_word = 32'h0000_0013;

    logic        s_clk_i, reset_i, i_hready_i, d_hready_i, d_hwrite_o;
    logic [31:0] boot_addr_i, i_haddr_o, i_hrdata_i, d_haddr_o, d_hwdata_o, d_hrdata_i;
    logic [1:0]  i_htrans_o, d_htrans_o;

    logic [31:0] lcg_q;
    logic [31:0] imem [prog_len];
    logic [31:0] dmem [256];                           // Words at 0x400 to 0x7FC
    logic [31:0] mdmem [256];
    logic [31:0] mregs [32];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic        i_dph, i_held, d_dph, d_held, d_dwr, fetch_seen, halt_seen;
    logic [31:0] i_dadr, i_hold_adr, d_dadr, d_hold_adr;
    int unsigned i_wait, d_wait, cycles;

    hardisc_lite DUT (.*);

    always #2 s_clk_i = ~s_clk_i;

    function automatic logic [31:0] next_rand();
        lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
        return {lcg_q[15:0], lcg_q[31:16]};            // Good bits low, where modulo reads them
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return next_rand() % n;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        off = (addr - boot_pc) >> 2;
        return (off < prog_len) ? imem[off[6:0]] : nop_word;
    endfunction

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic compare_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            end_with_failure($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        if (exp_addr.size() == 0) begin
            end_with_failure("The core wrote to the data bus after the last expected store");
        end else begin
            compare_value("store address", addr, exp_addr.pop_front());
            compare_value("store data", data, exp_data.pop_front());
            if (addr[31:10] == 22'd1) begin
                dmem[addr[9:2]] = data;
            end
            halt_seen = (addr == `HALT_ADDR);
        end
    endtask

    task automatic drive_ready(input logic dph, inout int unsigned left, output logic ready);
        if (dph) begin
            ready = (left == 0);
            if (left != 0) begin
                left = left - 1;
            end
        end else begin
            ready = (rand_below(4) != 0);              // Holds an address phase now and then
        end
    endtask

    task automatic build_program();
        logic [31:0] ins;
        logic [11:0] off;
        logic [12:0] bimm;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2, last_rd;
        int unsigned skip;
        last_rd = 5'd1;
        for (int i = 0; i < 96; i++) begin
            rd   = 5'(1 + rand_below(15));
            rs1  = (rand_below(2) == 0) ? last_rd : 5'(1 + rand_below(15));  // Back-to-back use
            rs2  = 5'(1 + rand_below(15));
            off  = 12'h400 + 12'(rand_below(256) * 4);
            skip = rand_below(4) + 1;
            if (i + 1 + skip > 96) begin
                skip = 95 - i;                         // Never jump into the closing stores
            end
            case (rand_below(16))
                0, 1, 2, 3: begin
                    ins     = {12'(rand_below(4096)), rs1, 3'b000, rd, 7'b0010011};
                    last_rd = rd;
                end
                4, 5, 6, 7: begin
                    case (rand_below(5))
                        0:       {f7, f3} = {7'h00, 3'b000};
                        1:       {f7, f3} = {7'h20, 3'b000};
                        2:       {f7, f3} = {7'h00, 3'b111};
                        3:       {f7, f3} = {7'h00, 3'b110};
                        default: {f7, f3} = {7'h00, 3'b100};
                    endcase
                    ins     = {f7, rs2, rs1, f3, rd, 7'b0110011};
                    last_rd = rd;
                end
                8: begin
                    ins     = next_rand();
                    ins     = {ins[19:0], rd, 7'b0110111};
                    last_rd = rd;
                end
                9, 10: begin
                    ins     = {off, 5'd0, 3'b010, rd, 7'b0000011};
                    last_rd = rd;                      // Next one often uses the loaded value
                end
                11, 12: ins = {off[11:5], rs1, 5'd0, 3'b010, off[4:0], 7'b0100011};
                13, 14: begin
                    bimm = 13'((skip + 1) * 4);
                    f3   = 3'(rand_below(2));          // BEQ or BNE
                    if (rand_below(2) == 0) begin
                        rs2 = rs1;
                    end
                    ins  = {bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11], 7'b1100011};
                end
                default: ins = 32'h0000_000F;          // FENCE, not supported
            endcase
            imem[i] = ins;
        end
        for (int r = 1; r < 16; r++) begin
            off         = 12'h780 + 12'(r * 4);
            imem[95 + r] = {off[11:5], 5'(r), 5'd0, 3'b010, off[4:0], 7'b0100011};
        end
        off       = 12'(`HALT_ADDR >> 1);               // Base plus offset reaches the halt address
        imem[111] = {off, 5'd0, 3'b000, 5'd1, 7'b0010011};
        imem[112] = {off[11:5], 5'd0, 5'd1, 3'b010, off[4:0], 7'b0100011};
    endtask

    // Instruction-set model, records every store in program order
    task automatic run_model();
        logic [31:0] ins, a, b, addr, res, imm_i, imm_s, imm_b;
        logic        wr;
        int unsigned idx;
        idx = 0;
        while (idx < prog_len) begin
            ins   = imem[idx];
            a     = mregs[ins[19:15]];
            b     = mregs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            wr    = 1'b0;
            res   = 32'd0;
            idx   = idx + 1;
            case (ins[6:0])
                7'b0010011: begin
                    wr  = (ins[14:12] == 3'b000);
                    res = a + imm_i;
                end
                7'b0110011: begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'b000:  res = ins[30] ? a - b : a + b;
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0110111: begin
                    wr  = 1'b1;
                    res = {ins[31:12], 12'd0};
                end
                7'b0000011: begin
                    addr = a + imm_i;
                    wr   = 1'b1;
                    res  = mdmem[addr[9:2]];
                end
                7'b0100011: begin
                    addr = a + imm_s;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    if (addr[31:10] == 22'd1) begin
                        mdmem[addr[9:2]] = b;
                    end
                end
                7'b1100011: begin
                    if ((ins[12] == 1'b0) == (a == b)) begin  // BEQ on equal, BNE otherwise
                        idx = idx - 1 + (imm_b >> 2);
                    end
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                mregs[ins[11:7]] = res;
            end
        end
    endtask

    // Bus slaves and protocol checks for both buses
    always @(posedge s_clk_i) begin
        if (reset_i) begin
            i_dph  = 1'b0;
            i_held = 1'b0;
            i_dadr = boot_pc;
            d_dph  = 1'b0;
            d_held = 1'b0;
            d_dadr = 32'd0;
        end else begin
            if (i_held) begin
                compare_value("i_htrans_o while held", 32'(i_htrans_o), 32'd2);
                compare_value("i_haddr_o while held", i_haddr_o, i_hold_adr);
            end
            if (d_held) begin
                compare_value("d_htrans_o while held", 32'(d_htrans_o), 32'd2);
                compare_value("d_haddr_o while held", d_haddr_o, d_hold_adr);
            end
            if (!fetch_seen && i_htrans_o == 2'b10) begin
                compare_value("first fetch address", i_haddr_o, boot_pc);
                fetch_seen = 1'b1;
            end
            i_held     = (i_htrans_o == 2'b10) && !i_hready_i;
            i_hold_adr = i_haddr_o;
            d_held     = (d_htrans_o == 2'b10) && !d_hready_i;
            d_hold_adr = d_haddr_o;
            if (i_hready_i) begin
                i_dph  = (i_htrans_o == 2'b10);
                i_dadr = i_haddr_o;
                i_wait = rand_below(4);
            end
            if (d_hready_i) begin
                if (d_dph && d_dwr) begin
                    check_store(d_dadr, d_hwdata_o);   // Write data phase ends here
                end
                d_dph  = (d_htrans_o == 2'b10);
                d_dadr = d_haddr_o;
                d_dwr  = d_hwrite_o;
                d_wait = rand_below(4);
            end
        end
        #1;
        drive_ready(i_dph, i_wait, i_hready_i);
        drive_ready(d_dph, d_wait, d_hready_i);
        i_hrdata_i = fetch_word(i_dadr);
        d_hrdata_i = (d_dadr[31:10] == 22'd1) ? dmem[d_dadr[9:2]] : 32'd0;
    end

    initial begin
        s_clk_i     = 1'b0;
        reset_i     = 1'b1;
        boot_addr_i = boot_pc;
        i_hrdata_i  = 32'd0;
        i_hready_i  = 1'b1;
        d_hrdata_i  = 32'd0;
        d_hready_i  = 1'b1;
        lcg_q       = 32'h8e65_2375;
        fetch_seen  = 1'b0;
        halt_seen   = 1'b0;
        for (int k = 0; k < 32; k++) begin
            mregs[k] = 32'd0;
        end
        for (int k = 0; k < 256; k++) begin
            dmem[k]  = next_rand();
            mdmem[k] = dmem[k];
        end
        build_program();
        run_model();

        @(posedge s_clk_i);
        @(negedge s_clk_i);
        compare_value("i_htrans_o during reset", 32'(i_htrans_o), 32'd0);
        compare_value("d_htrans_o during reset", 32'(d_htrans_o), 32'd0);
        @(posedge s_clk_i);
        #1 reset_i = 1'b0;
        @(negedge s_clk_i);
        compare_value("i_htrans_o after reset", 32'(i_htrans_o), 32'd0);
        compare_value("d_htrans_o after reset", 32'(d_htrans_o), 32'd0);
        compare_value("d_hwrite_o after reset", 32'(d_hwrite_o), 32'd0);

        cycles = 0;
        while (!halt_seen && cycles < 20000) begin
            @(negedge s_clk_i);
            cycles++;
        end
        if (!halt_seen) begin
            end_with_failure("Timed out after 20000 cycles without a store to the halt address");
        end else if (exp_addr.size() != 0) begin
            end_with_failure("The program halted before all expected stores were seen");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- hardisc_lite.sv
// Three stage RV32I subset core
`timescale 1ns/10ps
`include "core_defs.svh"

module hardisc_lite (
    input  logic             s_clk_i,
    input  logic             reset_i,
    input  logic [`XLEN-1:0] boot_addr_i,       // First fetch address

    output logic [`XLEN-1:0] i_haddr_o,         // Instruction bus
    output logic [1:0]       i_htrans_o,
    input  logic [31:0]      i_hrdata_i,
    input  logic             i_hready_i,

    output logic [`XLEN-1:0] d_haddr_o,         // Data bus
    output logic [1:0]       d_htrans_o,
    output logic             d_hwrite_o,
    output logic [`XLEN-1:0] d_hwdata_o,
    input  logic [`XLEN-1:0] d_hrdata_i,
    input  logic             d_hready_i
);

    logic [4:0]       s_rs1, s_rs2, s_wb_rd;
    logic [`XLEN-1:0] s_rs1_val, s_rs2_val, s_wb_val;
    logic             s_wb_en;

    feex_if s_feex ();
    exma_if s_exma ();

    pipeline_1_fe m_pipe_1_fe (
        .s_clk_i(s_clk_i),
        .reset_i(reset_i),
        .boot_addr_i(boot_addr_i),
        .i_haddr_o(i_haddr_o),
        .i_htrans_o(i_htrans_o),
        .i_hrdata_i(i_hrdata_i),
        .i_hready_i(i_hready_i),
        .feex(s_feex.fe)
    );

    pipeline_2_ex m_pipe_2_ex (
        .s_clk_i(s_clk_i),
        .reset_i(reset_i),
        .feex(s_feex.ex),
        .exma(s_exma.ex),
        .rs1_o(s_rs1),
        .rs2_o(s_rs2),
        .rs1_val_i(s_rs1_val),
        .rs2_val_i(s_rs2_val)
    );

    pipeline_3_ma m_pipe_3_ma (
        .s_clk_i(s_clk_i),
        .reset_i(reset_i),
        .exma(s_exma.ma),
        .d_haddr_o(d_haddr_o),
        .d_htrans_o(d_htrans_o),
        .d_hwrite_o(d_hwrite_o),
        .d_hwdata_o(d_hwdata_o),
        .d_hrdata_i(d_hrdata_i),
        .d_hready_i(d_hready_i),
        .wb_en_o(s_wb_en),
        .wb_rd_o(s_wb_rd),
        .wb_val_o(s_wb_val)
    );

    rf_controller m_rfc (
        .s_clk_i(s_clk_i),
        .reset_i(reset_i),
        .wb_en_i(s_wb_en),
        .wb_rd_i(s_wb_rd),
        .wb_val_i(s_wb_val),
        .rs1_i(s_rs1),
        .rs2_i(s_rs2),
        .rs1_val_o(s_rs1_val),
        .rs2_val_o(s_rs2_val)
    );

endmodule

//--- rf_controller.sv
// Integer register file
`timescale 1ns/10ps
`include "core_defs.svh"

module rf_controller (
    input  logic             s_clk_i,
    input  logic             reset_i,
    input  logic             wb_en_i,
    input  logic [4:0]       wb_rd_i,
    input  logic [`XLEN-1:0] wb_val_i,
    input  logic [4:0]       rs1_i,
    input  logic [4:0]       rs2_i,
    output logic [`XLEN-1:0] rs1_val_o,
    output logic [`XLEN-1:0] rs2_val_o
);

    logic [`XLEN-1:0] regs [`RF_REGS];

    // Same-cycle write is visible to the reader
    function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wb_en_i && wb_rd_i == addr) begin
            return wb_val_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `RF_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_rd_i != 5'd0) begin
            regs[wb_rd_i] <= wb_val_i;          // x0 stays zero
        end
    end

    always_comb begin
        rs1_val_o = read_port(rs1_i);
        rs2_val_o = read_port(rs2_i);
    end

endmodule

//--- pipeline_3_ma.sv
// Memory access and writeback stage
`timescale 1ns/10ps
`include "core_defs.svh"

module pipeline_3_ma (
    input  logic             s_clk_i,
    input  logic             reset_i,
    exma_if.ma               exma,
    output logic [`XLEN-1:0] d_haddr_o,
    output logic [1:0]       d_htrans_o,
    output logic             d_hwrite_o,
    output logic [`XLEN-1:0] d_hwdata_o,
    input  logic [`XLEN-1:0] d_hrdata_i,
    input  logic             d_hready_i,
    output logic             wb_en_o,
    output logic [4:0]       wb_rd_o,
    output logic [`XLEN-1:0] wb_val_o
);

    core_pkg::ma_state_e state_q, state_d, ma_state;
    logic                is_mem, ld_done_q;
    logic [`XLEN-1:0]    rdata_q, wdata_q;

    assign is_mem   = exma.ictrl.is_load | exma.ictrl.is_store;
    // A fresh load or store goes straight into its address phase
    assign ma_state = (state_q == core_pkg::MA_IDLE && exma.valid && is_mem) ? core_pkg::MA_ADDR
                                                                            : state_q;

    always_comb begin
        case (ma_state)
            core_pkg::MA_ADDR: state_d = d_hready_i ? core_pkg::MA_DATA : core_pkg::MA_ADDR;
            core_pkg::MA_DATA: state_d = d_hready_i ? core_pkg::MA_IDLE : core_pkg::MA_DATA;
            default:           state_d = core_pkg::MA_IDLE;
        endcase
    end

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            state_q   <= core_pkg::MA_IDLE;
            ld_done_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            ld_done_q <= (ma_state == core_pkg::MA_DATA) & d_hready_i & exma.ictrl.is_load;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (ma_state == core_pkg::MA_ADDR && d_hready_i) begin
            wdata_q <= exma.wdata;              // Driven through the data phase
        end
        if (ma_state == core_pkg::MA_DATA && d_hready_i) begin
            rdata_q <= d_hrdata_i;
        end
    end

    assign d_haddr_o  = exma.val;
    assign d_htrans_o = (ma_state == core_pkg::MA_ADDR) ? 2'b10 : 2'b00;  // NONSEQ or IDLE
    assign d_hwrite_o = (ma_state == core_pkg::MA_ADDR) & exma.ictrl.is_store;
    assign d_hwdata_o = wdata_q;

    assign exma.busy  = (ma_state != core_pkg::MA_IDLE);

    // ALU results retire on handover, loads one cycle after the data phase
    assign wb_en_o  = ld_done_q | (exma.valid & exma.ictrl.wr_rd & ~exma.ictrl.is_load);
    assign wb_rd_o  = exma.rd;
    assign wb_val_o = ld_done_q ? rdata_q : exma.val;

    assign exma.fwd_valid = wb_en_o;
    assign exma.fwd_rd    = wb_rd_o;
    assign exma.fwd_val   = wb_val_o;

    // A held address phase belongs to a load or store and keeps its address
    a_nonseq: assert property (@(posedge s_clk_i) disable iff (reset_i)
        (d_htrans_o == 2'b10 && !d_hready_i) |->
            is_mem ##1 (d_htrans_o == 2'b10 && $stable(d_haddr_o)));

endmodule

//--- pipeline_2_ex.sv
// Decode and execute stage
`timescale 1ns/10ps
`include "core_defs.svh"

module pipeline_2_ex (
    input  logic             s_clk_i,
    input  logic             reset_i,
    feex_if.ex               feex,
    exma_if.ex               exma,
    output logic [4:0]       rs1_o,
    output logic [4:0]       rs2_o,
    input  logic [`XLEN-1:0] rs1_val_i,
    input  logic [`XLEN-1:0] rs2_val_i
);

    core_pkg::opcode_e opcode;
    core_pkg::alu_op_e alu_op;
    core_pkg::ictrl_t  ictrl;
    logic [`XLEN-1:0]  imm, op1, op2, opb, result;
    logic [2:0]        funct3;
    logic              use_imm, is_branch, taken, move;

    assign opcode = core_pkg::opcode_e'(feex.instr[6:0]);
    assign funct3 = feex.instr[14:12];
    assign rs1_o  = feex.instr[19:15];
    assign rs2_o  = feex.instr[24:20];

    always_comb begin
        alu_op    = core_pkg::ALU_ADD;
        imm       = {{20{feex.instr[31]}}, feex.instr[31:20]};  // I-type
        ictrl     = '0;
        use_imm   = 1'b1;
        is_branch = 1'b0;
        case (opcode)
            core_pkg::OP_IMM: begin
                ictrl.wr_rd = (funct3 == 3'b000);  // ADDI only
            end
            core_pkg::OP: begin
                use_imm     = 1'b0;
                ictrl.wr_rd = 1'b1;
                case (funct3)
                    3'b000:  alu_op = feex.instr[30] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                    3'b100:  alu_op = core_pkg::ALU_XOR;
                    3'b110:  alu_op = core_pkg::ALU_OR;
                    3'b111:  alu_op = core_pkg::ALU_AND;
                    default: ictrl.wr_rd = 1'b0;
                endcase
            end
            core_pkg::LUI: begin
                alu_op      = core_pkg::ALU_PASS_B;
                imm         = {feex.instr[31:12], 12'b0};
                ictrl.wr_rd = 1'b1;
            end
            core_pkg::LOAD: begin
                ictrl.wr_rd   = 1'b1;
                ictrl.is_load = 1'b1;
            end
            core_pkg::STORE: begin
                imm            = {{20{feex.instr[31]}}, feex.instr[31:25], feex.instr[11:7]};
                ictrl.is_store = 1'b1;
            end
            core_pkg::BRANCH: begin
                imm       = {{19{feex.instr[31]}}, feex.instr[31], feex.instr[7],
                             feex.instr[30:25], feex.instr[11:8], 1'b0};
                is_branch = 1'b1;
            end
            default: ;                                  // Retires as a no-op
        endcase
    end

    // Memory access result wins over the register file
    assign op1 = (exma.fwd_valid && exma.fwd_rd == rs1_o && rs1_o != 5'd0) ? exma.fwd_val
                                                                          : rs1_val_i;
    assign op2 = (exma.fwd_valid && exma.fwd_rd == rs2_o && rs2_o != 5'd0) ? exma.fwd_val
                                                                          : rs2_val_i;
    assign opb = use_imm ? imm : op2;

    always_comb begin
        case (alu_op)
            core_pkg::ALU_SUB:    result = op1 - opb;
            core_pkg::ALU_AND:    result = op1 & opb;
            core_pkg::ALU_OR:     result = op1 | opb;
            core_pkg::ALU_XOR:    result = op1 ^ opb;
            core_pkg::ALU_PASS_B: result = opb;
            default:              result = op1 + opb;
        endcase
    end

    // BEQ and BNE only
    assign taken = is_branch & (funct3[2:1] == 2'b00) & (funct3[0] ^ (op1 == op2));

    // Busy lasts until a load's data is forwardable, so it also covers load-use
    assign feex.stall    = exma.busy;
    assign move          = feex.valid & ~feex.stall;
    assign feex.redirect = move & taken;
    assign feex.target   = feex.pc + imm;

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            exma.valid <= 1'b0;
        end else begin
            exma.valid <= move;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (move) begin
            exma.ictrl <= ictrl;
            exma.rd    <= feex.instr[11:7];
            exma.val   <= result;
            exma.wdata <= op2;
        end
    end

    a_handover: assert property (@(posedge s_clk_i) disable iff (reset_i)
        (exma.valid && (exma.ictrl.is_load || exma.ictrl.is_store)) |-> exma.busy);

endmodule

//--- pipeline_1_fe.sv
// Instruction fetch stage
`timescale 1ns/10ps
`include "core_defs.svh"

module pipeline_1_fe (
    input  logic             s_clk_i,
    input  logic             reset_i,
    input  logic [`XLEN-1:0] boot_addr_i,
    output logic [`XLEN-1:0] i_haddr_o,
    output logic [1:0]       i_htrans_o,
    input  logic [31:0]      i_hrdata_i,
    input  logic             i_hready_i,
    feex_if.fe               feex
);

    logic             aphase_q, dphase_q, drop_q, ir_valid_q;
    logic [31:0]      ir_q;
    logic [`XLEN-1:0] ir_pc_q, pc_q, haddr_q, fetch_addr;
    logic             d_done, take, in_flight, ir_valid_d, issue;

    assign d_done     = dphase_q & i_hready_i;
    assign take       = ir_valid_q & ~feex.stall;
    assign in_flight  = aphase_q | (dphase_q & ~i_hready_i);  // Still on the bus after this edge
    assign fetch_addr = feex.redirect ? feex.target : pc_q;

    // Redirect empties the register, a dropped reply never lands
    assign ir_valid_d = feex.redirect       ? 1'b0 :
                        (d_done & ~drop_q)  ? 1'b1 :
                        take                ? 1'b0 : ir_valid_q;
    assign issue      = ~in_flight & ~ir_valid_d;

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            aphase_q   <= 1'b0;
            dphase_q   <= 1'b0;
            drop_q     <= 1'b0;
            ir_valid_q <= 1'b0;
            pc_q       <= boot_addr_i;
        end else begin
            aphase_q   <= issue | (aphase_q & ~i_hready_i);
            dphase_q   <= (aphase_q & i_hready_i) | (dphase_q & ~i_hready_i);
            drop_q     <= feex.redirect ? in_flight : (drop_q & ~d_done);
            ir_valid_q <= ir_valid_d;
            if (issue) begin
                pc_q <= fetch_addr + 32'd4;
            end else if (feex.redirect) begin
                pc_q <= feex.target;
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (issue) begin
            haddr_q <= fetch_addr;
        end
        if (d_done) begin
            ir_q    <= i_hrdata_i;
            ir_pc_q <= haddr_q;                 // Held since the address phase
        end
    end

    assign i_haddr_o  = haddr_q;
    assign i_htrans_o = aphase_q ? 2'b10 : 2'b00;  // NONSEQ or IDLE
    assign feex.valid = ir_valid_q;
    assign feex.instr = ir_q;
    assign feex.pc    = ir_pc_q;

    a_addr_hold: assert property (@(posedge s_clk_i) disable iff (reset_i)
        (i_htrans_o == 2'b10 && !i_hready_i) |=> (i_htrans_o == 2'b10 && $stable(i_haddr_o)));

endmodule

//--- stage_if.sv
// Stage boundary interfaces
`timescale 1ns/10ps
`include "core_defs.svh"

interface feex_if;
    logic             valid;        // Instruction register is full
    logic [31:0]      instr;
    logic [`XLEN-1:0] pc;
    logic             stall;
    logic             redirect;     // Taken branch leaves execute
    logic [`XLEN-1:0] target;

    modport fe (output valid, instr, pc, input stall, redirect, target);
    modport ex (input valid, instr, pc, output stall, redirect, target);
endinterface

interface exma_if;
    logic                valid;     // Pulse in the cycle after handover
    core_pkg::ictrl_t    ictrl;
    logic [4:0]          rd;
    logic [`XLEN-1:0]    val;       // ALU result or access address
    logic [`XLEN-1:0]    wdata;
    logic                busy;
    logic                fwd_valid;
    logic [4:0]          fwd_rd;
    logic [`XLEN-1:0]    fwd_val;

    modport ex (
        output valid, ictrl, rd, val, wdata,
        input  busy, fwd_valid, fwd_rd, fwd_val
    );
    modport ma (
        input  valid, ictrl, rd, val, wdata,
        output busy, fwd_valid, fwd_rd, fwd_val
    );
endinterface

//--- core_pkg.sv
// Core types
package core_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B          // LUI immediate
    } alu_op_e;

    // Execute to memory access control
    typedef struct packed {
        logic wr_rd;        // Result goes to rd
        logic is_load;
        logic is_store;
    } ictrl_t;

    typedef enum logic [1:0] {
        MA_IDLE,
        MA_ADDR,            // Address phase on the data bus
        MA_DATA             // Waiting out the data phase
    } ma_state_e;

endpackage

//--- core_defs.svh
// Core width and address constants
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width
`define XLEN 32

// Architectural registers
`define RF_REGS 32

// A store to this address ends the program
`define HALT_ADDR 32'h0000_0FFC

`endif
